// File: rtl/render_params.svh
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// Line geometry
`define CHARS_PER_LINE 8
`define GLYPH_ROWS     20 // Rows of one character cell
`define PIXELS_PER_ROW 16

`define OUT_CREDITS    4  // Sink buffer depth after reset

`endif

// File: rtl/char_pkg.sv
`include "render_params.svh"

package char_pkg;

  typedef logic [7:0] ascii_t;

  // Column within the text line
  typedef logic [$clog2(`CHARS_PER_LINE)-1:0] char_idx_t;

  typedef struct packed {
    ascii_t code;
  } char_beat_t;

endpackage

// File: rtl/pixel_pkg.sv
`include "render_params.svh"

package pixel_pkg;

  typedef logic [$clog2(`GLYPH_ROWS)-1:0] row_idx_t;

  // Leftmost pixel in the MSB
  typedef logic [`PIXELS_PER_ROW-1:0] pixel_row_t;

  typedef struct packed {
    row_idx_t            row;
    char_pkg::char_idx_t col;
    pixel_row_t          pixels;
    logic                last;   // Final beat of the line
  } pixel_beat_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SCAN,
    S_RELEASE
  } scan_state_t;

endpackage

// File: rtl/char_ingress.sv
`timescale 1ns/1ps
`include "render_params.svh"

module char_ingress import char_pkg::*; (
  input  logic                             end_of_line,
  input  logic                             rst,
  input  logic                             in_valid,
  input  char_beat_t                       in_beat,
  input  logic                             line_release,
  output logic                             in_credit,
  output logic                             line_full,
  output ascii_t [`CHARS_PER_LINE-1:0]     line_chars
);

  localparam int ret_w = $clog2(`CHARS_PER_LINE + 1);

  char_idx_t        wr_ptr;
  logic [ret_w-1:0] ret_cnt;   // Credits still owed to the sender
  logic             wr_en;

  // Sender must not send into a full line, drop it if it does
  assign wr_en = in_valid && !line_full;

  always_ff @(posedge end_of_line) begin
    if (rst) begin
      wr_ptr    <= '0;
      line_full <= 1'b0;
      ret_cnt   <= '0;
    end else begin
      if (line_release) begin
        wr_ptr    <= '0;
        line_full <= 1'b0;
        ret_cnt   <= ret_w'(`CHARS_PER_LINE);   // Every slot is free again
      end else begin
        if (wr_en) begin
          wr_ptr <= wr_ptr + 1'b1;
          if (wr_ptr == char_idx_t'(`CHARS_PER_LINE - 1)) begin
            line_full <= 1'b1;
          end
        end
        if (ret_cnt != '0) begin
          ret_cnt <= ret_cnt - 1'b1;
        end
      end
    end
  end

  // One credit per cycle until the freed slots are all returned
  assign in_credit = (ret_cnt != '0);

  always_ff @(posedge end_of_line) begin
    if (wr_en) begin
      line_chars[wr_ptr] <= in_beat.code;
    end
  end

endmodule

// File: rtl/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom import char_pkg::*, pixel_pkg::*; (
  input  ascii_t     ascii,
  input  row_idx_t   row,
  output pixel_row_t pixel_row
);

  localparam pixel_row_t arch_row  = 16'h3FC0;  // Rounded top or bottom
  localparam pixel_row_t sides_row = 16'hC030;
  localparam pixel_row_t bar_row   = 16'hFFF0;
  localparam pixel_row_t stem_row  = 16'h0030;  // Right stroke only

  always_comb begin
    pixel_row = '0;
    case (ascii)
      8'h41: begin  // A
        case (row) inside
          [5'd4:5'd5]:   pixel_row = arch_row;
          [5'd6:5'd9]:   pixel_row = sides_row;
          [5'd10:5'd11]: pixel_row = bar_row;
          [5'd12:5'd15]: pixel_row = sides_row;
          default:       pixel_row = '0;
        endcase
      end

      8'h48: begin  // H
        case (row) inside
          [5'd4:5'd7]:   pixel_row = sides_row;
          [5'd8:5'd9]:   pixel_row = bar_row;
          [5'd10:5'd15]: pixel_row = sides_row;
          default:       pixel_row = '0;
        endcase
      end

      8'h4A: begin  // J
        case (row) inside
          [5'd4:5'd9]:   pixel_row = stem_row;
          [5'd10:5'd15]: pixel_row = sides_row;
          [5'd16:5'd17]: pixel_row = arch_row;  // Hook at the bottom
          default:       pixel_row = '0;
        endcase
      end

      8'h4F: begin  // O
        case (row) inside
          [5'd4:5'd5]:   pixel_row = arch_row;
          [5'd6:5'd13]:  pixel_row = sides_row;
          [5'd14:5'd15]: pixel_row = arch_row;
          default:       pixel_row = '0;
        endcase
      end

      // Space and every code without a glyph stay blank
      default: begin
        pixel_row = '0;
      end
    endcase
  end

endmodule

// File: rtl/row_sequencer.sv
`timescale 1ns/1ps
`include "render_params.svh"

module row_sequencer import char_pkg::*, pixel_pkg::*; (
  input  logic                         end_of_line,
  input  logic                         rst,
  input  logic                         line_full,
  input  ascii_t [`CHARS_PER_LINE-1:0] line_chars,
  input  pixel_row_t                   rom_pixels,
  input  logic                         out_credit,
  output ascii_t                       rom_ascii,
  output row_idx_t                     rom_row,
  output logic                         out_valid,
  output pixel_beat_t                  out_beat,
  output logic                         line_release
);

  localparam int cred_w = $clog2(`OUT_CREDITS + 1);

  scan_state_t       state;
  row_idx_t          cur_row;
  char_idx_t         cur_col;
  logic [cred_w-1:0] cred_cnt;
  logic              row_end;
  logic              last_pos;
  logic              scan_done;
  logic              fire;

  assign row_end   = (cur_col == char_idx_t'(`CHARS_PER_LINE - 1));
  assign last_pos  = row_end && (cur_row == row_idx_t'(`GLYPH_ROWS - 1));
  assign scan_done = out_valid && out_beat.last;

  // The beat on the output still holds its credit this cycle
  assign fire = (state == S_SCAN) && !scan_done && (cred_cnt > cred_w'(out_valid));

  assign rom_ascii    = line_chars[cur_col];
  assign rom_row      = cur_row;
  assign line_release = (state == S_RELEASE);

  always_ff @(posedge end_of_line) begin
    if (rst) begin
      state     <= S_IDLE;
      cur_row   <= '0;
      cur_col   <= '0;
      out_valid <= 1'b0;
      cred_cnt  <= cred_w'(`OUT_CREDITS);
    end else begin
      out_valid <= fire;
      cred_cnt  <= cred_cnt + cred_w'(out_credit) - cred_w'(out_valid);

      case (state)
        S_IDLE: begin
          if (line_full) begin
            state <= S_SCAN;
          end
        end
        S_SCAN: begin
          if (scan_done) begin
            state <= S_RELEASE;   // Wait for the last beat to leave
          end
        end
        S_RELEASE: begin
          state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase

      // Row-major walk, held in place while out of credits
      if (fire) begin
        if (row_end) begin
          cur_col <= '0;
          cur_row <= last_pos ? '0 : cur_row + 1'b1;
        end else begin
          cur_col <= cur_col + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge end_of_line) begin
    if (fire) begin
      out_beat.row    <= cur_row;
      out_beat.col    <= cur_col;
      out_beat.pixels <= rom_pixels;
      out_beat.last   <= last_pos;
    end
  end

endmodule

// File: rtl/text_line_renderer.sv
`timescale 1ns/1ps
`include "render_params.svh"

module text_line_renderer import char_pkg::*, pixel_pkg::*; (
  input  logic        end_of_line,
  input  logic        rst,
  input  logic        in_valid,
  input  char_beat_t  in_beat,
  input  logic        out_credit,
  output logic        in_credit,
  output logic        out_valid,
  output pixel_beat_t out_beat
);

  logic                         line_full;
  logic                         line_release;
  ascii_t [`CHARS_PER_LINE-1:0] line_chars;
  ascii_t                       rom_ascii;
  row_idx_t                     rom_row;
  pixel_row_t                   rom_pixels;

  char_ingress char_ingress_i (
    .end_of_line  (end_of_line),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_beat      (in_beat),
    .line_release (line_release),
    .in_credit    (in_credit),
    .line_full    (line_full),
    .line_chars   (line_chars)
  );

  glyph_rom glyph_rom_i (
    .ascii     (rom_ascii),
    .row       (rom_row),
    .pixel_row (rom_pixels)
  );

  row_sequencer row_sequencer_i (
    .end_of_line  (end_of_line),
    .rst          (rst),
    .line_full    (line_full),
    .line_chars   (line_chars),
    .rom_pixels   (rom_pixels),
    .out_credit   (out_credit),
    .rom_ascii    (rom_ascii),
    .rom_row      (rom_row),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .line_release (line_release)
  );

endmodule

// File: tests/text_line_renderer_assert.sv
`timescale 1ns/1ps
`include "render_params.svh"

module text_line_renderer_assert import char_pkg::*, pixel_pkg::*; (
  input logic        end_of_line,
  input logic        rst,
  input logic        in_valid,
  input logic        line_full,
  input logic        line_release,
  input logic        out_valid,
  input logic        out_credit,
  input pixel_beat_t out_beat
);

  int credits;  // Shadow of the sequencer's output credit count
  int fail_cnt = 0;

  always_ff @(posedge end_of_line) begin
    if (rst) begin
      credits <= `OUT_CREDITS;
    end else begin
      credits <= credits + int'(out_credit) - int'(out_valid);
    end
  end

  no_write_when_full: assert property (@(posedge end_of_line) disable iff (rst)
    in_valid |-> !line_full)
    else begin
      fail_cnt++;
      $error("in_valid arrived while the line buffer was full");
    end

  beat_has_credit: assert property (@(posedge end_of_line) disable iff (rst)
    out_valid |-> credits > 0)
    else begin
      fail_cnt++;
      $error("out_valid with no output credit left");
    end

  last_at_end: assert property (@(posedge end_of_line) disable iff (rst)
    out_valid && out_beat.last |->
      out_beat.row == row_idx_t'(`GLYPH_ROWS - 1) &&
      out_beat.col == char_idx_t'(`CHARS_PER_LINE - 1))
    else begin
      fail_cnt++;
      $error("last flag set away from the final row and column");
    end

  release_clears_full: assert property (@(posedge end_of_line) disable iff (rst)
    line_release |=> !line_full)
    else begin
      fail_cnt++;
      $error("line_full still high after line_release");
    end

endmodule

// File: tests/tb_text_line_renderer.sv
`timescale 1ns/1ps
`include "render_params.svh"

module tb_text_line_renderer import char_pkg::*, pixel_pkg::*; ();

  localparam int line_beats      = `CHARS_PER_LINE * `GLYPH_ROWS;
  localparam int lines_sent      = 6;
  localparam int watchdog_cycles = lines_sent * 5 * 200;
  localparam int wait_limit      = 2000;  // Cycles for any single wait loop
  localparam int log_depth       = 2048;
  localparam int sink_next       = 0;
  localparam int sink_hold       = 1;
  localparam int sink_random     = 2;

  typedef ascii_t [`CHARS_PER_LINE-1:0] line_t;

  logic        end_of_line;
  logic        rst;
  logic        in_valid;
  char_beat_t  in_beat;
  logic        out_credit;
  logic        in_credit;
  logic        out_valid;
  pixel_beat_t out_beat;

  pixel_beat_t beat_log [log_depth];
  int    beats_total    = 0;
  int    in_credit_seen = 0;
  int    line_base      = 0;  // First log index of the current line
  int    sent_total     = 0;
  int    credits_back   = 0;
  int    sink_gap       = 0;
  int    value_errs     = 0;
  int    other_errs     = 0;
  int    assert_errs    = 0;
  string test_name      = "none";

  text_line_renderer text_line_renderer_i (
    .end_of_line (end_of_line),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .out_credit  (out_credit),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_beat    (out_beat)
  );

  bind text_line_renderer text_line_renderer_assert text_line_renderer_assert_i (.*);

  initial end_of_line = 1'b0;
  always #5 end_of_line = ~end_of_line;

  // Sampled mid-cycle so readers at the same edge see the previous counts
  always @(negedge end_of_line) begin
    if (in_credit === 1'b1) begin
      in_credit_seen <= in_credit_seen + 1;
    end
    if (out_valid === 1'b1) begin
      if (beats_total < log_depth) begin
        beat_log[beats_total] <= out_beat;
      end
      beats_total <= beats_total + 1;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errs++;
      $display("** Error [%s] %s: expected %0h, actual %0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      other_errs++;
      $display("Failure in %s: %s", test_name, what);
    end
  endtask

  function automatic bit between(input int v, input int lo, input int hi);
    return v >= lo && v <= hi;
  endfunction

  // Reference glyphs A, H, J and O with every other code blank
  function automatic pixel_row_t glyph_model(input ascii_t code, input int row);
    pixel_row_t arc;
    pixel_row_t sides;
    pixel_row_t bar;
    pixel_row_t stem;
    pixel_row_t result;
    arc    = 16'h3FC0;
    sides  = 16'hC030;
    bar    = 16'hFFF0;
    stem   = 16'h0030;
    result = '0;
    case (code)
      8'h41: begin
        if (between(row, 4, 5)) result = arc;
        else if (between(row, 10, 11)) result = bar;
        else if (between(row, 6, 9) || between(row, 12, 15)) result = sides;
      end
      8'h48: begin
        if (between(row, 8, 9)) result = bar;
        else if (between(row, 4, 15)) result = sides;
      end
      8'h4A: begin
        if (between(row, 4, 9)) result = stem;
        else if (between(row, 10, 15)) result = sides;
        else if (between(row, 16, 17)) result = arc;
      end
      8'h4F: begin
        if (between(row, 4, 5) || between(row, 14, 15)) result = arc;
        else if (between(row, 6, 13)) result = sides;
      end
      default: result = '0;
    endcase
    return result;
  endfunction

  function automatic line_t line_from_text(input string text);
    line_t chars;
    int    i;
    for (i = 0; i < `CHARS_PER_LINE; i++) begin
      chars[i] = text[i];
    end
    return chars;
  endfunction

  // Sends one character per cycle whenever a sender credit is left
  task automatic send_line(input line_t chars);
    int col;
    col       = 0;
    line_base = beats_total;
    while (col < `CHARS_PER_LINE) begin
      @(negedge end_of_line);
      if (`CHARS_PER_LINE + in_credit_seen - sent_total > 0) begin
        in_valid     = 1'b1;
        in_beat.code = chars[col];
        sent_total++;
        col++;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(negedge end_of_line);
    in_valid = 1'b0;
  endtask

  // One sink cycle that returns at most one credit
  task automatic sink_step(input int mode);
    bit give;
    give = 1'b0;
    @(negedge end_of_line);
    if (beats_total > credits_back) begin
      case (mode)
        sink_next: give = 1'b1;
        sink_random: begin
          if (sink_gap == 0) begin
            give     = 1'b1;
            sink_gap = int'($urandom_range(1, 4));
          end else begin
            sink_gap--;
          end
        end
        default: give = 1'b0;
      endcase
    end
    out_credit = give;
    if (give) credits_back++;
  endtask

  task automatic drain_line(input line_t chars, input int mode);
    int          cycles;
    int          got;
    int          k;
    pixel_beat_t beat;
    cycles = 0;
    while ((beats_total - line_base < line_beats || credits_back < beats_total ||
            in_credit_seen < sent_total) && cycles < wait_limit) begin
      sink_step(mode);
      cycles++;
    end
    check_true(cycles < wait_limit, "line did not finish rendering in time");
    repeat (4) sink_step(mode);  // Catch any extra beat or credit
    got = beats_total - line_base;
    check_value("beat count", line_beats, got);
    check_value("in_credit pulses", sent_total, in_credit_seen);
    for (k = 0; k < got && k < line_beats; k++) begin
      beat = beat_log[line_base + k];
      check_value($sformatf("row of beat %0d", k), k / `CHARS_PER_LINE, 32'(beat.row));
      check_value($sformatf("col of beat %0d", k), k % `CHARS_PER_LINE, 32'(beat.col));
      check_value($sformatf("pixels of beat %0d", k),
                  32'(glyph_model(chars[k % `CHARS_PER_LINE], k / `CHARS_PER_LINE)),
                  32'(beat.pixels));
      check_value($sformatf("last of beat %0d", k), 32'(k == line_beats - 1),
                  32'(beat.last));
    end
  endtask

  task automatic idle_after_reset();
    test_name = "reset";
    repeat (10) begin
      @(negedge end_of_line);
      check_value("out_valid", 0, 32'(out_valid));
      check_value("in_credit", 0, 32'(in_credit));
    end
  endtask

  task automatic render_hajo();
    line_t chars;
    test_name = "render_hajo";
    chars     = line_from_text("HAJOHAJO");
    send_line(chars);
    drain_line(chars, sink_next);
  endtask

  task automatic blank_unknown_codes();
    line_t chars;
    test_name = "unknown_codes";
    chars[0]  = 8'h20;
    chars[1]  = 8'h3F;  // '?'
    chars[2]  = 8'h61;  // Lower case a
    chars[3]  = 8'h68;
    chars[4]  = 8'h00;
    chars[5]  = 8'hFF;
    chars[6]  = 8'h42;
    chars[7]  = 8'h5A;
    send_line(chars);
    drain_line(chars, sink_next);
  endtask

  task automatic stall_on_held_credits();
    line_t chars;
    int    cycles;
    test_name = "backpressure";
    chars     = line_from_text("OHJAAJHO");
    cycles    = 0;
    send_line(chars);
    while (beats_total - line_base < `OUT_CREDITS && cycles < wait_limit) begin
      sink_step(sink_hold);
      cycles++;
    end
    check_true(cycles < wait_limit, "no beats arrived while credits were held");
    repeat (20) begin
      sink_step(sink_hold);
      check_value("out_valid while stalled", 0, 32'(out_valid));
    end
    check_value("beats before stall", `OUT_CREDITS, beats_total - line_base);
    sink_gap = 0;
    drain_line(chars, sink_random);
  endtask

  task automatic lines_on_returned_credits();
    ascii_t pool [6];
    line_t  chars;
    int     n;
    int     i;
    pool[0] = 8'h41;
    pool[1] = 8'h48;
    pool[2] = 8'h4A;
    pool[3] = 8'h4F;
    pool[4] = 8'h20;
    pool[5] = 8'h3F;
    for (n = 0; n < 3; n++) begin
      test_name = $sformatf("credit_lines_%0d", n);
      for (i = 0; i < `CHARS_PER_LINE; i++) begin
        chars[i] = pool[$urandom_range(0, 5)];
      end
      send_line(chars);
      drain_line(chars, sink_next);
    end
  endtask

  initial begin
    void'($urandom(32'h136c9677));
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_credit = 1'b0;
    repeat (5) @(negedge end_of_line);
    rst = 1'b0;
    idle_after_reset();
    render_hajo();
    blank_unknown_codes();
    stall_on_held_credits();
    lines_on_returned_credits();
    assert_errs = text_line_renderer_i.text_line_renderer_assert_i.fail_cnt;
    $display("Checks done: %0d value errors, %0d other errors, %0d assertion failures",
             value_errs, other_errs, assert_errs);
    if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge end_of_line);
    $display("Timeout: run did not end within %0d cycles", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/char_pkg.sv
rtl/pixel_pkg.sv
rtl/char_ingress.sv
rtl/glyph_rom.sv
rtl/row_sequencer.sv
rtl/text_line_renderer.sv
tests/text_line_renderer_assert.sv
tests/tb_text_line_renderer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_text_line_renderer
FILELIST  ?= verilog.f
LOG       ?= sim.log
FAIL_MSG  := Simulation FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
